// ==== verilog/cpuPkg.sv ====
package cpuPkg;

   // Widths fixed by the instruction set
   typedef logic [7:0]  dataT;
   typedef logic [7:0]  addrT;
   typedef logic [15:0] instrT;
   typedef logic [2:0]  regIdxT;

   // Opcode field, instruction bits 15..11
   typedef enum logic [4:0] {
      OpNop  = 5'h00,
      OpAdd  = 5'h01,
      OpAddi = 5'h02,
      OpAdc  = 5'h03,
      OpAdci = 5'h04,
      OpSub  = 5'h05,
      OpAnd  = 5'h06,
      OpOr   = 5'h07,
      OpXor  = 5'h08,
      OpMov  = 5'h09,
      OpLdi  = 5'h0a,
      OpLd   = 5'h0b,
      OpSt   = 5'h0c,
      OpJmp  = 5'h0d,
      OpJz   = 5'h0e,
      OpCall = 5'h0f,
      OpRet  = 5'h10,
      OpHalt = 5'h11
   } opcodeT;

   typedef enum logic [2:0] {
      FnAdd  = 3'd0,
      FnSub  = 3'd1,
      FnAnd  = 3'd2,
      FnOr   = 3'd3,
      FnXor  = 3'd4,
      FnPass = 3'd5
   } aluFnT;

   // Next PC source
   typedef enum logic [1:0] {
      PcNext   = 2'd0,
      PcImm    = 2'd1,
      PcImmIfZ = 2'd2,
      PcLr     = 2'd3
   } pcSelT;

   // Major states of the sequencer
   typedef enum logic [2:0] {
      FetchSetup  = 3'd0,
      FetchAccess = 3'd1,
      Decode      = 3'd2,
      Execute     = 3'd3,
      MemAccess   = 3'd4,
      Halt        = 3'd5
   } seqStateT;

   // Decoded control word, 28 bits
   typedef struct packed {
      aluFnT  aluFn;
      logic   useImm;
      logic   useCarry;
      logic   regWe;
      logic   wdSel;
      logic   flagWe;
      logic   memRead;
      logic   memWrite;
      pcSelT  pcSel;
      logic   lrWe;
      logic   halt;
      regIdxT rd;
      regIdxT rs;
      dataT   imm;
   } controlT;

   typedef struct packed {
      dataT aluOut;
      logic zero;
      logic carry;
   } resultT;

endpackage

// ==== verilog/apbRequester.sv ====
`timescale 1ns/10ps

module apbRequester import cpuPkg::*; (
   input  logic  Clock,
   input  logic  nReset,
   input  logic  busReq,
   input  logic  busWrite,
   input  addrT  busAddr,
   input  instrT busWdata,
   output logic  busDone,
   output instrT busRdata,
   output logic  PSEL,
   output logic  PENABLE,
   output logic  PWRITE,
   output addrT  PADDR,
   output instrT PWDATA,
   input  instrT PRDATA,
   input  logic  PREADY,
   output logic  [7:0] StoreCount
);

   // Setup phase is an idle cycle with busReq high
   typedef enum logic {
      PhaseIdle,
      PhaseAccess
   } apbPhaseT;

   apbPhaseT phase;
   logic     setup;
   addrT     addrQ;
   logic     writeQ;
   instrT    wdataQ;

   // Bus stays quiet while reset is held
   assign setup = nReset && (phase == PhaseIdle) && busReq;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         phase      <= PhaseIdle;
         StoreCount <= '0;
      end else begin
         case (phase)
            PhaseIdle   : if (busReq) phase <= PhaseAccess;
            PhaseAccess : if (PREADY) phase <= PhaseIdle;
            default     : phase <= PhaseIdle;
         endcase
         // One count per completed write
         if (busDone && writeQ)
            StoreCount <= StoreCount + 8'd1;
      end
   end

   // Request held from setup to completion
   always_ff @(posedge Clock) begin
      if (setup) begin
         addrQ  <= busAddr;
         writeQ <= busWrite;
         wdataQ <= busWdata;
      end
   end

   assign PSEL     = setup || (phase == PhaseAccess);
   assign PENABLE  = (phase == PhaseAccess);
   assign PADDR    = PENABLE ? addrQ : busAddr;
   assign PWRITE   = PENABLE ? writeQ : (setup && busWrite);
   assign PWDATA   = PENABLE ? wdataQ : busWdata;
   assign busDone  = PENABLE && PREADY;
   assign busRdata = PRDATA;

   // Access only after a setup cycle
   enableAfterSetup: assert property (@(posedge Clock) disable iff (!nReset)
      $rose(PENABLE) |-> (PSEL && $past(PSEL)));

   // Covers the setup to access handover too
   addrStableUntilDone: assert property (@(posedge Clock) disable iff (!nReset)
      (PSEL && !busDone) |=> $stable(PADDR));

endmodule

// ==== verilog/controlSequencer.sv ====
`timescale 1ns/10ps

module controlSequencer import cpuPkg::*; (
   input  logic    Clock,
   input  logic    nReset,
   input  addrT    pc,
   input  logic    busDone,
   input  instrT   busRdata,
   input  dataT    rdData,
   input  dataT    rsData,
   input  logic    halted,
   output logic    busReq,
   output logic    busWrite,
   output addrT    busAddr,
   output instrT   busWdata,
   output controlT ctrl,
   output logic    execStrobe,
   output dataT    loadData
);

   seqStateT state;
   instrT    ir;
   logic     memOp;

   // Opcode to control word
   function automatic controlT decodeInstr(instrT instr);
      controlT c;
      c       = '0;
      c.aluFn = FnPass;
      c.pcSel = PcNext;
      c.rd    = instr[10:8];
      c.rs    = instr[2:0];
      c.imm   = instr[7:0];
      case (opcodeT'(instr[15:11]))
         OpAdd  : begin
            c.aluFn  = FnAdd;
            c.regWe  = 1'b1;
            c.flagWe = 1'b1;
         end
         OpAddi : begin
            c.aluFn  = FnAdd;
            c.useImm = 1'b1;
            c.regWe  = 1'b1;
            c.flagWe = 1'b1;
         end
         OpAdc  : begin
            c.aluFn    = FnAdd;
            c.useCarry = 1'b1;
            c.regWe    = 1'b1;
            c.flagWe   = 1'b1;
         end
         OpAdci : begin
            c.aluFn    = FnAdd;
            c.useImm   = 1'b1;
            c.useCarry = 1'b1;
            c.regWe    = 1'b1;
            c.flagWe   = 1'b1;
         end
         OpSub  : begin
            c.aluFn  = FnSub;
            c.regWe  = 1'b1;
            c.flagWe = 1'b1;
         end
         OpAnd  : begin
            c.aluFn  = FnAnd;
            c.regWe  = 1'b1;
            c.flagWe = 1'b1;
         end
         OpOr   : begin
            c.aluFn  = FnOr;
            c.regWe  = 1'b1;
            c.flagWe = 1'b1;
         end
         OpXor  : begin
            c.aluFn  = FnXor;
            c.regWe  = 1'b1;
            c.flagWe = 1'b1;
         end
         // Copies, flags untouched
         OpMov  : c.regWe = 1'b1;
         OpLdi  : begin
            c.useImm = 1'b1;
            c.regWe  = 1'b1;
         end
         OpLd   : begin
            c.memRead = 1'b1;
            c.regWe   = 1'b1;
            c.wdSel   = 1'b1;
         end
         OpSt   : c.memWrite = 1'b1;
         OpJmp  : c.pcSel = PcImm;
         OpJz   : c.pcSel = PcImmIfZ;
         OpCall : begin
            c.pcSel = PcImm;
            c.lrWe  = 1'b1;
         end
         OpRet  : c.pcSel = PcLr;
         OpHalt : c.halt = 1'b1;
         // NOP and unused codes
         default : c.aluFn = FnPass;
      endcase
      return c;
   endfunction

   assign memOp = ctrl.memRead || ctrl.memWrite;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         state <= FetchSetup;
         ctrl  <= '0;
      end else begin
         case (state)
            // No new fetch once halted
            FetchSetup  : state <= halted ? Halt : FetchAccess;
            FetchAccess : if (busDone) state <= Decode;
            Decode      : state <= Execute;
            Execute     : state <= memOp ? MemAccess : FetchSetup;
            MemAccess   : if (busDone) state <= FetchSetup;
            Halt        : state <= Halt;
            default     : state <= FetchSetup;
         endcase
         if (state == Decode)
            ctrl <= decodeInstr(ir);
      end
   end

   // Instruction register
   always_ff @(posedge Clock) begin
      if (state == FetchAccess && busDone)
         ir <= busRdata;
   end

   assign busReq   = (state == FetchSetup && !halted) || (state == FetchAccess) ||
                     (state == MemAccess);
   assign busWrite = (state == MemAccess) && ctrl.memWrite;
   // Data address from rs, fetch address from PC
   assign busAddr  = (state == MemAccess) ? rsData : pc;
   assign busWdata = {8'h00, rdData};
   // Load byte written back on the completing edge
   assign loadData = busRdata[7:0];

   assign execStrobe = (state == Execute && !memOp) || (state == MemAccess && busDone);

   // One strobe per instruction, then the next fetch
   strobeEndsInstr: assert property (@(posedge Clock) disable iff (!nReset)
      execStrobe |=> (state == FetchSetup));

endmodule

// ==== verilog/executeUnit.sv ====
`timescale 1ns/10ps

module executeUnit import cpuPkg::*; (
   input  logic    Clock,
   input  logic    nReset,
   input  controlT ctrl,
   input  logic    execStrobe,
   input  dataT    wbData,
   output dataT    rdData,
   output dataT    rsData,
   output resultT  aluResult,
   output logic    zFlag
);

   dataT       regs [8];
   logic       cFlag;
   dataT       opB;
   logic       carryIn;
   logic [8:0] sum;
   logic [8:0] diff;

   // Two read ports
   assign rdData = regs[ctrl.rd];
   assign rsData = regs[ctrl.rs];

   // Operand B is rs or the immediate
   assign opB     = ctrl.useImm ? ctrl.imm : rsData;
   assign carryIn = ctrl.useCarry && cFlag;
   assign sum     = {1'b0, rdData} + {1'b0, opB} + {8'h00, carryIn};
   // Top bit is the borrow
   assign diff    = {1'b0, rdData} - {1'b0, opB};

   always_comb begin
      case (ctrl.aluFn)
         FnAdd  : begin
            aluResult.aluOut = sum[7:0];
            aluResult.carry  = sum[8];
         end
         FnSub  : begin
            aluResult.aluOut = diff[7:0];
            aluResult.carry  = diff[8];
         end
         // Logic ops clear carry
         FnAnd  : begin
            aluResult.aluOut = rdData & opB;
            aluResult.carry  = 1'b0;
         end
         FnOr   : begin
            aluResult.aluOut = rdData | opB;
            aluResult.carry  = 1'b0;
         end
         FnXor  : begin
            aluResult.aluOut = rdData ^ opB;
            aluResult.carry  = 1'b0;
         end
         default : begin
            aluResult.aluOut = opB;
            aluResult.carry  = cFlag;
         end
      endcase
      aluResult.zero = (aluResult.aluOut == 8'h00);
   end

   // Register file
   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         for (int i = 0; i < 8; i++)
            regs[i] <= '0;
      end else if (execStrobe && ctrl.regWe) begin
         regs[ctrl.rd] <= wbData;
      end
   end

   // Flags, only arithmetic and logic ops
   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         zFlag <= 1'b0;
         cFlag <= 1'b0;
      end else if (execStrobe && ctrl.flagWe) begin
         zFlag <= aluResult.zero;
         cFlag <= aluResult.carry;
      end
   end

   noWriteOnStore: assert property (@(posedge Clock) disable iff (!nReset)
      execStrobe |-> !(ctrl.regWe && ctrl.memWrite));

endmodule

// ==== verilog/resultUnit.sv ====
`timescale 1ns/10ps

module resultUnit import cpuPkg::*; #(
   parameter addrT ResetVector = 8'h00
) (
   input  logic    Clock,
   input  logic    nReset,
   input  controlT ctrl,
   input  logic    execStrobe,
   input  resultT  aluResult,
   input  logic    zFlag,
   input  dataT    loadData,
   output dataT    wbData,
   output addrT    pc,
   output logic    halted
);

   addrT lr;
   addrT pcPlusOne;

   // Writeback source
   assign wbData    = ctrl.wdSel ? loadData : aluResult.aluOut;
   // One 16-bit word per address
   assign pcPlusOne = pc + 8'd1;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         pc <= ResetVector;
      end else if (execStrobe) begin
         case (ctrl.pcSel)
            PcNext   : pc <= pcPlusOne;
            PcImm    : pc <= ctrl.imm;
            // Z from the last flag-setting op
            PcImmIfZ : pc <= zFlag ? ctrl.imm : pcPlusOne;
            PcLr     : pc <= lr;
            default  : pc <= pcPlusOne;
         endcase
      end
   end

   // Link register, return address of CALL
   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         lr <= '0;
      else if (execStrobe && ctrl.lrWe)
         lr <= pcPlusOne;
   end

   // Sticky until reset
   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         halted <= 1'b0;
      else if (execStrobe && ctrl.halt)
         halted <= 1'b1;
   end

endmodule

// ==== verilog/cpuTop.sv ====
`timescale 1ns/10ps

module cpuTop import cpuPkg::*; #(
   parameter addrT ResetVector = 8'h00
) (
   input  logic  Clock,
   input  logic  nReset,
   output logic  PSEL,
   output logic  PENABLE,
   output logic  PWRITE,
   output addrT  PADDR,
   output instrT PWDATA,
   input  instrT PRDATA,
   input  logic  PREADY,
   output logic  Halted,
   output logic  [7:0] StoreCount
);

   // Sequencer to requester
   logic    busReq;
   logic    busWrite;
   addrT    busAddr;
   instrT   busWdata;
   logic    busDone;
   instrT   busRdata;

   // Datapath
   controlT ctrl;
   logic    execStrobe;
   dataT    rdData;
   dataT    rsData;
   resultT  aluResult;
   logic    zFlag;
   dataT    wbData;
   dataT    loadData;
   addrT    pc;

   controlSequencer controlSequencer_i (
      .Clock      (Clock),
      .nReset     (nReset),
      .pc         (pc),
      .busDone    (busDone),
      .busRdata   (busRdata),
      .rdData     (rdData),
      .rsData     (rsData),
      .halted     (Halted),
      .busReq     (busReq),
      .busWrite   (busWrite),
      .busAddr    (busAddr),
      .busWdata   (busWdata),
      .ctrl       (ctrl),
      .execStrobe (execStrobe),
      .loadData   (loadData)
   );

   executeUnit executeUnit_i (
      .Clock      (Clock),
      .nReset     (nReset),
      .ctrl       (ctrl),
      .execStrobe (execStrobe),
      .wbData     (wbData),
      .rdData     (rdData),
      .rsData     (rsData),
      .aluResult  (aluResult),
      .zFlag      (zFlag)
   );

   resultUnit #(
      .ResetVector (ResetVector)
   ) resultUnit_i (
      .Clock      (Clock),
      .nReset     (nReset),
      .ctrl       (ctrl),
      .execStrobe (execStrobe),
      .aluResult  (aluResult),
      .zFlag      (zFlag),
      .loadData   (loadData),
      .wbData     (wbData),
      .pc         (pc),
      .halted     (Halted)
   );

   apbRequester apbRequester_i (
      .Clock      (Clock),
      .nReset     (nReset),
      .busReq     (busReq),
      .busWrite   (busWrite),
      .busAddr    (busAddr),
      .busWdata   (busWdata),
      .busDone    (busDone),
      .busRdata   (busRdata),
      .PSEL       (PSEL),
      .PENABLE    (PENABLE),
      .PWRITE     (PWRITE),
      .PADDR      (PADDR),
      .PWDATA     (PWDATA),
      .PRDATA     (PRDATA),
      .PREADY     (PREADY),
      .StoreCount (StoreCount)
   );

endmodule

// ==== bench/apbMemoryModel.sv ====
`timescale 1ns/10ps

module apbMemoryModel import cpuPkg::*; (
   input  logic  Clock,
   input  logic  nReset,
   input  logic  PSEL,
   input  logic  PENABLE,
   input  logic  PWRITE,
   input  addrT  PADDR,
   input  instrT PWDATA,
   output instrT PRDATA,
   output logic  PREADY
);

   // Word-addressed, 256 entries of 16 bits
   instrT       mem [256];
   logic [31:0] lfsrState;
   logic [1:0]  lowCount;

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] lfsrStep(logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 32'h80200003;
      return n;
   endfunction

   // Fill pattern from the whole address
   initial begin
      for (int a = 0; a < 256; a++)
         mem[a] = {8'(a) ^ 8'hc3, 8'(a)};
   end

   assign PRDATA = mem[PADDR];

   // Random wait states, never more than three in a row
   always @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         PREADY    <= 1'b0;
         lfsrState <= 32'hc1a26d9d;
         lowCount  <= '0;
      end else begin
         lfsrState <= lfsrStep(lfsrState);
         if (lfsrState[0] || lowCount == 2'd3) begin
            PREADY   <= 1'b1;
            lowCount <= '0;
         end else begin
            PREADY   <= 1'b0;
            lowCount <= lowCount + 2'd1;
         end
      end
   end

   // Write lands on the completing edge
   always @(posedge Clock) begin
      if (nReset && PSEL && PENABLE && PREADY && PWRITE)
         mem[PADDR] <= PWDATA;
   end

endmodule

// ==== bench/cpuTopTb.sv ====
`timescale 1ns/10ps

module cpuTopTb import cpuPkg::*;;

   localparam addrT ResetVector = 8'h10;
   localparam int   InstrCount  = 42;
   localparam int   WorstWait   = 3;
   localparam int   CycleLimit  = 8 * InstrCount * (WorstWait + 1) + 100;
   localparam addrT MarkerAddr  = 8'hfe;

   logic        Clock;
   logic        nReset;
   logic        PSEL;
   logic        PENABLE;
   logic        PWRITE;
   addrT        PADDR;
   instrT       PWDATA;
   instrT       PRDATA;
   logic        PREADY;
   logic        Halted;
   logic [7:0]  StoreCount;

   dataT        expected [8];
   logic [7:0]  storeSeen;
   logic        firstSetupSeen;
   int          cycles;

   cpuTop #(.ResetVector(ResetVector)) cpuTop_i (
      .Clock (Clock), .nReset (nReset),
      .PSEL (PSEL), .PENABLE (PENABLE), .PWRITE (PWRITE),
      .PADDR (PADDR), .PWDATA (PWDATA), .PRDATA (PRDATA), .PREADY (PREADY),
      .Halted (Halted), .StoreCount (StoreCount)
   );

   apbMemoryModel memModel_i (
      .Clock (Clock), .nReset (nReset),
      .PSEL (PSEL), .PENABLE (PENABLE), .PWRITE (PWRITE),
      .PADDR (PADDR), .PWDATA (PWDATA), .PRDATA (PRDATA),
      .PREADY (PREADY)
   );

   task automatic stopRun(string msg);
      $display("%s", msg);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic reportMismatch(string msg);
      stopRun($sformatf("ERR %0t: %s", $time, msg));
   endtask

   function automatic instrT enc(opcodeT op, regIdxT rd, logic [7:0] low);
      return {op, rd, low};
   endfunction

   task automatic loadProgram();
      instrT p [InstrCount];
      p[0]  = enc(OpLdi, 1, 8'h5a);
      p[1]  = enc(OpLdi, 2, 8'h3c);
      p[2]  = enc(OpAdd, 1, 8'd2);
      p[3]  = enc(OpLdi, 7, 8'hf0);
      p[4]  = enc(OpSt, 1, 8'd7);
      p[5]  = enc(OpSub, 1, 8'd2);
      p[6]  = enc(OpXor, 1, 8'd2);
      p[7]  = enc(OpOr, 1, 8'd2);
      p[8]  = enc(OpAnd, 1, 8'd2);
      p[9]  = enc(OpAddi, 1, 8'h05);
      p[10] = enc(OpMov, 4, 8'd1);
      p[11] = enc(OpAddi, 7, 8'h01);
      p[12] = enc(OpSt, 4, 8'd7);
      // 16-bit add 0x12f0 + 0x0135, low bytes carry
      p[13] = enc(OpLdi, 1, 8'hf0);
      p[14] = enc(OpLdi, 2, 8'h35);
      p[15] = enc(OpLdi, 3, 8'h12);
      p[16] = enc(OpLdi, 4, 8'h01);
      p[17] = enc(OpAdd, 1, 8'd2);
      p[18] = enc(OpAdc, 3, 8'd4);
      p[19] = enc(OpAddi, 7, 8'h01);
      p[20] = enc(OpSt, 1, 8'd7);
      p[21] = enc(OpAddi, 7, 8'h01);
      p[22] = enc(OpSt, 3, 8'd7);
      // Taken JZ skips the marker store
      p[23] = enc(OpLdi, 5, MarkerAddr);
      p[24] = enc(OpSub, 2, 8'd2);
      p[25] = enc(OpJz, 0, ResetVector + 8'd27);
      p[26] = enc(OpSt, 5, 8'd5);
      p[27] = enc(OpAddi, 2, 8'h01);
      // Z clear, falls through
      p[28] = enc(OpJz, 0, ResetVector + 8'd31);
      p[29] = enc(OpAddi, 7, 8'h01);
      p[30] = enc(OpSt, 2, 8'd7);
      p[31] = enc(OpCall, 0, ResetVector + 8'd40);
      p[32] = enc(OpAddi, 7, 8'h01);
      p[33] = enc(OpSt, 6, 8'd7);
      p[34] = enc(OpLdi, 0, 8'he0);
      p[35] = enc(OpLd, 1, 8'd0);
      p[36] = enc(OpAddi, 1, 8'h11);
      p[37] = enc(OpAddi, 7, 8'h01);
      p[38] = enc(OpSt, 1, 8'd7);
      p[39] = enc(OpHalt, 0, 8'h00);
      // Subroutine
      p[40] = enc(OpLdi, 6, 8'ha5);
      p[41] = enc(OpRet, 0, 8'h00);
      for (int i = 0; i < InstrCount; i++)
         memModel_i.mem[ResetVector + 8'(i)] = p[i];
      memModel_i.mem[8'he0] = 16'h0033;
   endtask

   // Expected stores by 8-bit wraparound rules
   task automatic computeExpected();
      dataT        r;
      logic [15:0] sum16;
      r           = 8'h5a + 8'h3c;
      expected[0] = r;
      r           = r - 8'h3c;
      r           = r ^ 8'h3c;
      r           = r | 8'h3c;
      r           = r & 8'h3c;
      expected[1] = r + 8'h05;
      sum16       = 16'h12f0 + 16'h0135;
      expected[2] = sum16[7:0];
      expected[3] = sum16[15:8];
      expected[4] = 8'h01;
      expected[5] = 8'ha5;
      expected[6] = 8'h33 + 8'h11;
      expected[7] = 8'h00;
   endtask

   initial begin
      Clock = 1'b0;
      forever #5 Clock = ~Clock;
   end

   // Protocol rules on every transfer
   setupThenAccess: assert property (@(posedge Clock) disable iff (!nReset)
      (PSEL && !PENABLE) |=> (PSEL && PENABLE))
      else reportMismatch("setup phase not followed by access phase");

   enableOnlyWithSelect: assert property (@(posedge Clock) disable iff (!nReset)
      PENABLE |-> PSEL)
      else reportMismatch("PENABLE high without PSEL");

   requestStable: assert property (@(posedge Clock) disable iff (!nReset)
      (PSEL && !(PENABLE && PREADY)) |=>
         ($stable(PADDR) && $stable(PWRITE) && $stable(PWDATA)))
      else reportMismatch("PADDR, PWRITE or PWDATA changed before PREADY");

   // Sticky halt, bus quiet afterwards
   haltSticky: assert property (@(posedge Clock) disable iff (!nReset)
      Halted |=> Halted)
      else reportMismatch("Halted dropped");

   noSelectAfterHalt: assert property (@(posedge Clock) disable iff (!nReset)
      Halted |-> !PSEL)
      else reportMismatch("PSEL raised after HALT");

   // Store data and addresses
   always @(posedge Clock) begin
      if (nReset && PSEL && PENABLE && PREADY && PWRITE) begin
         assert (PADDR != MarkerAddr)
            else reportMismatch("store hit the marker address");
         assert (PWDATA[15:8] == 8'h00)
            else reportMismatch($sformatf("store high byte %h not zero", PWDATA[15:8]));
         if (PADDR[7:3] == 5'b11110) begin
            assert (PWDATA[7:0] == expected[PADDR[2:0]])
               else reportMismatch($sformatf("store to %h got %h, expected %h",
                  PADDR, PWDATA[7:0], expected[PADDR[2:0]]));
            storeSeen[PADDR[2:0]] <= 1'b1;
         end
      end
   end

   // First fetch comes from the reset vector
   always @(posedge Clock) begin
      if (nReset && PSEL && !PENABLE && !firstSetupSeen) begin
         firstSetupSeen <= 1'b1;
         assert (PADDR == ResetVector)
            else reportMismatch($sformatf("first PADDR %h, expected %h", PADDR, ResetVector));
      end
   end

   always @(posedge Clock) begin
      cycles <= cycles + 1;
      if (cycles > CycleLimit)
         stopRun($sformatf("Timeout: CPU did not halt within %0d cycles", CycleLimit));
   end

   initial begin
      nReset         = 1'b0;
      storeSeen      = '0;
      firstSetupSeen = 1'b0;
      cycles         = 0;
      computeExpected();
      @(posedge Clock);
      loadProgram();
      @(negedge Clock);
      assert (!PSEL && !PENABLE && !PWRITE && !Halted && StoreCount == 8'd0)
         else reportMismatch("outputs not idle during reset");
      // Released after two rising edges in reset
      @(posedge Clock);
      nReset <= 1'b1;
      @(negedge Clock);
      assert (!PENABLE && !Halted && StoreCount == 8'd0)
         else reportMismatch("outputs not idle right after reset");
      wait (Halted);
      // Watch the bus stay idle for a while
      repeat (20) @(negedge Clock);
      assert (StoreCount == 8'd7)
         else reportMismatch($sformatf("StoreCount %0d, expected 7", StoreCount));
      assert (storeSeen[6:0] == 7'h7f)
         else reportMismatch($sformatf("stores seen %b, expected 1111111", storeSeen[6:0]));
      assert (memModel_i.mem[8'hf5] == {8'h00, expected[5]})
         else reportMismatch("return-path store missing");
      $display("All tests passed");
      $finish;
   end

endmodule

// ==== cpuTop.f ====
verilog/cpuPkg.sv
verilog/apbRequester.sv
verilog/controlSequencer.sv
verilog/executeUnit.sv
verilog/resultUnit.sv
verilog/cpuTop.sv
bench/apbMemoryModel.sv
bench/cpuTopTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f cpuTop.f --top-module cpuTopTb \
   -o simCpuTop > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/simCpuTop > sim.log 2>&1
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || exit 1
exit 0
